// File: all.f
source/dtw_pkg.sv
source/dtw_fifo.sv
source/dtw_regs.sv
source/dtw_ref_loader.sv
source/dtw_engine.sv
source/dtw_accel.sv
testbench/tb_dtw_accel.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DTW accelerator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_dtw_accel -o tb_dtw_accel \
    && ./obj_dir/tb_dtw_accel > sim.log 2>&1 \
    || { echo "Build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// File: source/dtw_accel.sv
// DTW accelerator top level, single clock domain on S_AXI_clk
// Register access uses plain strobes, the host waits for each ack

`timescale 1ns/100ps

module dtw_accel #(
    parameter int SRC_DEPTH  = 4,
    parameter int SINK_DEPTH = 4,
    parameter int REF_DEPTH  = 64,
    parameter int QUERY_LEN  = 4
) (
    input  logic              S_AXI_clk,
    input  logic              w_axi_rst,
    input  dtw_pkg::reg_req_t i_reg_req,
    input  logic              i_reg_in_rdy,
    input  logic              i_reg_out_req,
    output logic              o_reg_in_ack_stb,
    output logic              o_reg_out_rdy_stb,
    output dtw_pkg::reg_rsp_t o_reg_rsp,
    input  logic              i_src_stb,
    input  dtw_pkg::sample_t  i_src_sample,
    output logic              o_src_ready,
    output dtw_pkg::score_t   o_sink_score,
    output logic              o_sink_valid,
    input  logic              i_sink_rd_stb
);

    import dtw_pkg::*;

    localparam int REF_AW = $clog2(REF_DEPTH);
    localparam int REF_LW = $clog2(REF_DEPTH + 1);

    // Control levels from the register block
    logic                w_core_rst;
    logic                w_run;
    logic                w_mode;
    reg_word_t           w_ref_len;
    reg_word_t           w_nquery;
    logic                w_busy;
    logic                w_load_done;

    // Source FIFO, shared by the loader and the engine
    logic                w_src_empty;
    logic                w_src_full;
    logic                w_src_rd_stb;
    logic                w_ldr_rd_stb;
    logic                w_eng_rd_stb;
    sample_t             w_src_head;

    // Reference memory read port
    logic [REF_LW - 1:0] w_ref_len_eff;
    logic [REF_AW - 1:0] w_ref_addr;
    sample_t             w_ref_sample;

    // Sink FIFO
    logic                w_sink_empty;
    logic                w_sink_full;
    logic                w_sink_w_stb;
    score_t              w_sink_w_score;

    assign w_src_rd_stb = w_ldr_rd_stb | w_eng_rd_stb;
    assign o_src_ready  = ~w_src_full;
    assign o_sink_valid = ~w_sink_empty;

    dtw_regs u_regs (
        .S_AXI_clk         (S_AXI_clk),
        .w_axi_rst         (w_axi_rst),
        .i_reg_req         (i_reg_req),
        .i_reg_in_rdy      (i_reg_in_rdy),
        .i_reg_out_req     (i_reg_out_req),
        .o_reg_in_ack_stb  (o_reg_in_ack_stb),
        .o_reg_out_rdy_stb (o_reg_out_rdy_stb),
        .o_reg_rsp         (o_reg_rsp),
        .o_core_rst        (w_core_rst),
        .o_run             (w_run),
        .o_mode            (w_mode),
        .o_ref_len         (w_ref_len),
        .i_busy            (w_busy),
        .i_load_done       (w_load_done),
        .i_src_empty       (w_src_empty),
        .i_src_full        (w_src_full),
        .i_sink_empty      (w_sink_empty),
        .i_sink_full       (w_sink_full),
        .i_nquery          (w_nquery)
    );

    dtw_fifo #(
        .DEPTH (SRC_DEPTH),
        .T     (sample_t)
    ) u_src_fifo (
        .S_AXI_clk (S_AXI_clk),
        .w_axi_rst (w_axi_rst),
        .i_clear   (w_core_rst),
        .i_w_stb   (i_src_stb),
        .i_w_data  (i_src_sample),
        .o_full    (w_src_full),
        .i_r_stb   (w_src_rd_stb),
        .o_r_data  (w_src_head),
        .o_empty   (w_src_empty)
    );

    dtw_ref_loader #(
        .REF_DEPTH (REF_DEPTH)
    ) u_ref_loader (
        .S_AXI_clk     (S_AXI_clk),
        .w_axi_rst     (w_axi_rst),
        .i_core_rst    (w_core_rst),
        .i_run         (w_run),
        .i_mode        (w_mode),
        .i_ref_len     (w_ref_len),
        .i_src_empty   (w_src_empty),
        .i_src_sample  (w_src_head),
        .o_src_rd_stb  (w_ldr_rd_stb),
        .o_load_done   (w_load_done),
        .o_ref_len_eff (w_ref_len_eff),
        .i_ref_addr    (w_ref_addr),
        .o_ref_sample  (w_ref_sample)
    );

    dtw_engine #(
        .REF_DEPTH (REF_DEPTH),
        .QUERY_LEN (QUERY_LEN)
    ) u_engine (
        .S_AXI_clk     (S_AXI_clk),
        .w_axi_rst     (w_axi_rst),
        .i_core_rst    (w_core_rst),
        .i_run         (w_run),
        .i_mode        (w_mode),
        .i_load_done   (w_load_done),
        .i_ref_len_eff (w_ref_len_eff),
        .i_src_empty   (w_src_empty),
        .i_src_sample  (w_src_head),
        .o_src_rd_stb  (w_eng_rd_stb),
        .o_ref_addr    (w_ref_addr),
        .i_ref_sample  (w_ref_sample),
        .o_sink_w_stb  (w_sink_w_stb),
        .o_sink_score  (w_sink_w_score),
        .i_sink_full   (w_sink_full),
        .o_busy        (w_busy),
        .o_nquery      (w_nquery)
    );

    // Scores survive a core reset until read out
    dtw_fifo #(
        .DEPTH (SINK_DEPTH),
        .T     (score_t)
    ) u_sink_fifo (
        .S_AXI_clk (S_AXI_clk),
        .w_axi_rst (w_axi_rst),
        .i_clear   (1'b0),
        .i_w_stb   (w_sink_w_stb),
        .i_w_data  (w_sink_w_score),
        .o_full    (w_sink_full),
        .i_r_stb   (i_sink_rd_stb),
        .o_r_data  (o_sink_score),
        .o_empty   (w_sink_empty)
    );

endmodule

// File: source/dtw_engine.sv
// Subsequence DTW, one cell per cycle, one query sample per row
// Costs saturate nowhere, samples are assumed small enough for 32 bits

`timescale 1ns/100ps

module dtw_engine #(
    parameter int REF_DEPTH = 64,
    parameter int QUERY_LEN = 4,
    localparam int AW = $clog2(REF_DEPTH),
    localparam int LW = $clog2(REF_DEPTH + 1)
) (
    input  logic               S_AXI_clk,
    input  logic               w_axi_rst,
    input  logic               i_core_rst,
    input  logic               i_run,
    input  logic               i_mode,
    input  logic               i_load_done,
    input  logic [LW - 1:0]    i_ref_len_eff,
    input  logic               i_src_empty,
    input  dtw_pkg::sample_t   i_src_sample,
    output logic               o_src_rd_stb,
    output logic [AW - 1:0]    o_ref_addr,
    input  dtw_pkg::sample_t   i_ref_sample,
    output logic               o_sink_w_stb,
    output dtw_pkg::score_t    o_sink_score,
    input  logic               i_sink_full,
    output logic               o_busy,
    output dtw_pkg::reg_word_t o_nquery
);

    import dtw_pkg::*;

    localparam int QW = (QUERY_LEN > 1) ? $clog2(QUERY_LEN) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SWEEP,
        S_PUSH
    } state_t;

    function automatic score_t min2(input score_t a, input score_t b);
        return (a < b) ? a : b;
    endfunction

    state_t          r_state;
    logic [QW - 1:0] r_qi;
    logic [AW - 1:0] r_col;
    reg_word_t       r_nquery;
    sample_t         r_q_sample;
    score_t          r_prev [REF_DEPTH];
    score_t          r_cur  [REF_DEPTH];
    score_t          r_left;
    score_t          r_min;

    logic            w_pop;
    logic            w_push;
    logic            w_last_col;
    logic            w_last_row;
    logic [AW - 1:0] w_col_prev;
    score_t          w_diff;
    score_t          w_pred;
    score_t          w_cost;

    assign w_pop      = (r_state == S_IDLE) & i_run & i_mode & i_load_done
                        & ~i_core_rst & ~i_src_empty;
    assign w_push     = (r_state == S_PUSH) & ~i_sink_full & ~i_core_rst;
    assign w_last_col = (LW'(r_col) == i_ref_len_eff - LW'(1));
    assign w_last_row = (r_qi == QW'(QUERY_LEN - 1));
    assign w_col_prev = (r_col == '0) ? '0 : r_col - AW'(1);

    // Cell cost from the absolute difference and the cheapest predecessor
    always_comb begin
        if (r_q_sample > i_ref_sample) begin
            w_diff = score_t'(r_q_sample - i_ref_sample);
        end else begin
            w_diff = score_t'(i_ref_sample - r_q_sample);
        end
        if (r_qi == '0) begin
            w_pred = '0;
        end else if (r_col == '0) begin
            w_pred = r_prev[r_col];
        end else begin
            w_pred = min2(min2(r_prev[r_col], r_prev[w_col_prev]), r_left);
        end
        w_cost = w_diff + w_pred;
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst | i_core_rst) begin
            r_state  <= S_IDLE;
            r_qi     <= '0;
            r_col    <= '0;
            r_nquery <= '0;
        end else begin
            case (r_state)
                S_IDLE: begin
                    if (w_pop) begin
                        r_col   <= '0;
                        r_state <= S_SWEEP;
                    end
                end
                S_SWEEP: begin
                    if (w_last_col) begin
                        r_col <= '0;
                        if (w_last_row) begin
                            r_qi    <= '0;
                            r_state <= S_PUSH;
                        end else begin
                            r_qi    <= r_qi + QW'(1);
                            r_state <= S_IDLE;
                        end
                    end else begin
                        r_col <= r_col + AW'(1);
                    end
                end
                S_PUSH: begin
                    if (w_push) begin
                        r_nquery <= r_nquery + 1'b1;
                        r_state  <= S_IDLE;
                    end
                end
                default: r_state <= S_IDLE;
            endcase
        end
    end

    // Row storage and running minimum of the final row
    always_ff @(posedge S_AXI_clk) begin
        if (w_pop) begin
            r_q_sample <= i_src_sample;
        end
        if (r_state == S_SWEEP) begin
            r_cur[r_col] <= w_cost;
            r_left       <= w_cost;
            if (w_last_row) begin
                r_min <= (r_col == '0) ? w_cost : min2(r_min, w_cost);
            end
            if (w_last_col) begin
                for (int k = 0; k < REF_DEPTH; k++) begin
                    r_prev[k] <= r_cur[k];
                end
                r_prev[r_col] <= w_cost;
            end
        end
    end

    assign o_src_rd_stb = w_pop;
    assign o_ref_addr   = r_col;
    assign o_sink_w_stb = w_push;
    assign o_sink_score = r_min;
    assign o_busy       = (r_state != S_IDLE) | (r_qi != '0);
    assign o_nquery     = r_nquery;

endmodule

// File: source/dtw_fifo.sv
// First-word-fall-through FIFO, head is visible while not empty
// Writes when full and reads when empty are dropped

`timescale 1ns/100ps

module dtw_fifo #(
    parameter int  DEPTH = 4,
    parameter type T     = logic [7:0]
) (
    input  logic S_AXI_clk,
    input  logic w_axi_rst,
    input  logic i_clear,
    input  logic i_w_stb,
    input  T     i_w_data,
    output logic o_full,
    input  logic i_r_stb,
    output T     o_r_data,
    output logic o_empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T                r_mem [DEPTH];
    logic [AW - 1:0] r_wptr;
    logic [AW - 1:0] r_rptr;
    logic [CW - 1:0] r_count;

    logic            w_do_write;
    logic            w_do_read;

    assign o_full     = (r_count == CW'(DEPTH));
    assign o_empty    = (r_count == '0);
    assign o_r_data   = r_mem[r_rptr];
    assign w_do_write = i_w_stb & ~o_full;
    assign w_do_read  = i_r_stb & ~o_empty;

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst | i_clear) begin
            r_wptr  <= '0;
            r_rptr  <= '0;
            r_count <= '0;
        end else begin
            if (w_do_write) begin
                r_wptr <= (r_wptr == AW'(DEPTH - 1)) ? '0 : r_wptr + AW'(1);
            end
            if (w_do_read) begin
                r_rptr <= (r_rptr == AW'(DEPTH - 1)) ? '0 : r_rptr + AW'(1);
            end
            // Count holds on a simultaneous read and write
            if (w_do_write & ~w_do_read) begin
                r_count <= r_count + CW'(1);
            end else if (w_do_read & ~w_do_write) begin
                r_count <= r_count - CW'(1);
            end
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_do_write) begin
            r_mem[r_wptr] <= i_w_data;
        end
    end

endmodule

// File: source/dtw_pkg.sv
// Shared types, register map and ID constants for the DTW accelerator
// Register word index is taken from address bits 5:2 only

package dtw_pkg;

    typedef logic [15:0] sample_t;
    typedef logic [31:0] score_t;
    typedef logic [31:0] reg_word_t;
    typedef logic [15:0] reg_addr_t;

    typedef struct packed {
        reg_addr_t addr;
        reg_word_t wdata;
    } reg_req_t;

    typedef struct packed {
        reg_word_t rdata;
        logic      invalid;
    } reg_rsp_t;

    // Register word indices
    localparam logic [3:0] REG_CONTROL = 4'd0;
    localparam logic [3:0] REG_STATUS  = 4'd1;
    localparam logic [3:0] REG_REF_LEN = 4'd2;
    localparam logic [3:0] REG_VERSION = 4'd3;
    localparam logic [3:0] REG_KEY     = 4'd4;
    localparam logic [3:0] REG_NQUERY  = 4'd5;

    // Control bits, mode 0 loads the reference and mode 1 runs queries
    localparam int CTRL_CORE_RST = 0;
    localparam int CTRL_RUN      = 1;
    localparam int CTRL_MODE     = 2;

    // Status bits
    localparam int ST_BUSY       = 0;
    localparam int ST_LOAD_DONE  = 1;
    localparam int ST_SRC_EMPTY  = 2;
    localparam int ST_SRC_FULL   = 3;
    localparam int ST_SINK_EMPTY = 4;
    localparam int ST_SINK_FULL  = 5;

    localparam logic [3:0] VER_MAJOR    = 4'd1;
    localparam logic [7:0] VER_MINOR    = 8'd0;
    localparam logic [3:0] VER_REVISION = 4'd0;

    localparam reg_word_t DTW_VERSION = {VER_MAJOR, VER_MINOR, VER_REVISION, 16'h0000};
    localparam reg_word_t DTW_KEY     = 32'h0ca7cafe;

endpackage

// File: source/dtw_ref_loader.sv
// Fills the reference memory from the source FIFO in load mode
// Length is clipped to 1..REF_DEPTH, a new load needs a core reset

`timescale 1ns/100ps

module dtw_ref_loader #(
    parameter int REF_DEPTH = 64,
    localparam int AW = $clog2(REF_DEPTH),
    localparam int LW = $clog2(REF_DEPTH + 1)
) (
    input  logic               S_AXI_clk,
    input  logic               w_axi_rst,
    input  logic               i_core_rst,
    input  logic               i_run,
    input  logic               i_mode,
    input  dtw_pkg::reg_word_t i_ref_len,
    input  logic               i_src_empty,
    input  dtw_pkg::sample_t   i_src_sample,
    output logic               o_src_rd_stb,
    output logic               o_load_done,
    output logic [LW - 1:0]    o_ref_len_eff,
    input  logic [AW - 1:0]    i_ref_addr,
    output dtw_pkg::sample_t   o_ref_sample
);

    import dtw_pkg::*;

    sample_t         r_mem [REF_DEPTH];
    logic [LW - 1:0] r_wptr;
    logic            r_load_done;

    logic [LW - 1:0] w_len_eff;
    logic            w_pop;

    // Zero maps to one, anything past the memory maps to its size
    always_comb begin
        if (i_ref_len == '0) begin
            w_len_eff = LW'(1);
        end else if (i_ref_len > reg_word_t'(REF_DEPTH)) begin
            w_len_eff = LW'(REF_DEPTH);
        end else begin
            w_len_eff = i_ref_len[LW - 1:0];
        end
    end

    assign w_pop = i_run & ~i_mode & ~r_load_done & ~i_core_rst & ~i_src_empty
                   & (r_wptr < w_len_eff);

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst | i_core_rst) begin
            r_wptr      <= '0;
            r_load_done <= 1'b0;
        end else begin
            if (w_pop) begin
                r_wptr <= r_wptr + LW'(1);
            end
            if (r_wptr >= w_len_eff) begin
                r_load_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_pop) begin
            r_mem[r_wptr[AW - 1:0]] <= i_src_sample;
        end
    end

    assign o_src_rd_stb  = w_pop;
    assign o_load_done   = r_load_done;
    assign o_ref_len_eff = w_len_eff;
    assign o_ref_sample  = r_mem[i_ref_addr];

endmodule

// File: source/dtw_regs.sv
// Register block on a strobe port, one access in flight at a time
// Write ack follows the write strobe by one cycle, read data by two

`timescale 1ns/100ps

module dtw_regs (
    input  logic               S_AXI_clk,
    input  logic               w_axi_rst,
    input  dtw_pkg::reg_req_t  i_reg_req,
    input  logic               i_reg_in_rdy,
    input  logic               i_reg_out_req,
    output logic               o_reg_in_ack_stb,
    output logic               o_reg_out_rdy_stb,
    output dtw_pkg::reg_rsp_t  o_reg_rsp,
    output logic               o_core_rst,
    output logic               o_run,
    output logic               o_mode,
    output dtw_pkg::reg_word_t o_ref_len,
    input  logic               i_busy,
    input  logic               i_load_done,
    input  logic               i_src_empty,
    input  logic               i_src_full,
    input  logic               i_sink_empty,
    input  logic               i_sink_full,
    input  dtw_pkg::reg_word_t i_nquery
);

    import dtw_pkg::*;

    reg_word_t  r_control;
    reg_word_t  r_ref_len;
    logic       r_in_ack_stb;
    logic       r_rd_pend;
    logic [3:0] r_rd_idx;
    logic       r_out_rdy_stb;
    logic       r_invalid;
    reg_word_t  r_rdata;

    logic [3:0] w_wr_idx;
    logic       w_wr_valid;
    logic       w_rd_valid;
    reg_word_t  w_rd_data;
    reg_word_t  w_status;

    assign w_wr_idx   = i_reg_req.addr[5:2];
    assign w_wr_valid = (w_wr_idx <= REG_NQUERY);

    always_comb begin
        w_status                = '0;
        w_status[ST_BUSY]       = i_busy;
        w_status[ST_LOAD_DONE]  = i_load_done;
        w_status[ST_SRC_EMPTY]  = i_src_empty;
        w_status[ST_SRC_FULL]   = i_src_full;
        w_status[ST_SINK_EMPTY] = i_sink_empty;
        w_status[ST_SINK_FULL]  = i_sink_full;
    end

    // Read mux on the index latched with the request
    always_comb begin
        w_rd_valid = 1'b1;
        case (r_rd_idx)
            REG_CONTROL: w_rd_data = r_control;
            REG_STATUS:  w_rd_data = w_status;
            REG_REF_LEN: w_rd_data = r_ref_len;
            REG_VERSION: w_rd_data = DTW_VERSION;
            REG_KEY:     w_rd_data = DTW_KEY;
            REG_NQUERY:  w_rd_data = i_nquery;
            default: begin
                w_rd_data  = '0;
                w_rd_valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst) begin
            r_control     <= '0;
            r_ref_len     <= '0;
            r_in_ack_stb  <= 1'b0;
            r_rd_pend     <= 1'b0;
            r_out_rdy_stb <= 1'b0;
            r_invalid     <= 1'b0;
        end else begin
            r_in_ack_stb  <= i_reg_in_rdy;
            // A write wins over a read in the same cycle
            r_rd_pend     <= i_reg_out_req & ~i_reg_in_rdy;
            r_out_rdy_stb <= r_rd_pend;
            r_invalid     <= (i_reg_in_rdy & ~w_wr_valid) | (r_rd_pend & ~w_rd_valid);
            if (i_reg_in_rdy) begin
                if (w_wr_idx == REG_CONTROL) begin
                    r_control <= i_reg_req.wdata;
                end
                if (w_wr_idx == REG_REF_LEN) begin
                    r_ref_len <= i_reg_req.wdata;
                end
            end
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (i_reg_out_req) begin
            r_rd_idx <= w_wr_idx;
        end
        if (r_rd_pend) begin
            r_rdata <= w_rd_data;
        end
    end

    assign o_reg_in_ack_stb  = r_in_ack_stb;
    assign o_reg_out_rdy_stb = r_out_rdy_stb;
    assign o_reg_rsp         = '{rdata: r_rdata, invalid: r_invalid};
    assign o_core_rst        = r_control[CTRL_CORE_RST];
    assign o_run             = r_control[CTRL_RUN];
    assign o_mode            = r_control[CTRL_MODE];
    assign o_ref_len         = r_ref_len;

endmodule

// File: testbench/tb_dtw_accel.sv
// Testbench for dtw_accel with default parameters and a reference of 8 samples
// Samples use 6 LFSR bits each so model costs stay small

`timescale 1ns/100ps

module tb_dtw_accel;

    import dtw_pkg::*;

    localparam int QUERY_LEN  = 4;
    localparam int REF_LEN    = 8;
    localparam int TIMEOUT    = 2000;
    localparam int POLL_LIMIT = 200;

    logic      S_AXI_clk;
    logic      w_axi_rst;
    reg_req_t  reg_req;
    logic      reg_in_rdy;
    logic      reg_out_req;
    logic      reg_in_ack_stb;
    logic      reg_out_rdy_stb;
    reg_rsp_t  reg_rsp;
    logic      src_stb;
    sample_t   src_sample;
    logic      src_ready;
    score_t    sink_score;
    logic      sink_valid;
    logic      sink_rd_stb;

    int        error_count;
    int        tests_passed;
    int        tests_failed;
    logic [7:0] lfsr_state;
    sample_t   ref_model [REF_LEN];
    sample_t   query_buf [QUERY_LEN];

    dtw_accel i_dut (
        .S_AXI_clk         (S_AXI_clk),
        .w_axi_rst         (w_axi_rst),
        .i_reg_req         (reg_req),
        .i_reg_in_rdy      (reg_in_rdy),
        .i_reg_out_req     (reg_out_req),
        .o_reg_in_ack_stb  (reg_in_ack_stb),
        .o_reg_out_rdy_stb (reg_out_rdy_stb),
        .o_reg_rsp         (reg_rsp),
        .i_src_stb         (src_stb),
        .i_src_sample      (src_sample),
        .o_src_ready       (src_ready),
        .o_sink_score      (sink_score),
        .o_sink_valid      (sink_valid),
        .i_sink_rd_stb     (sink_rd_stb)
    );

    initial begin
        S_AXI_clk = 1'b0;
        forever #4 S_AXI_clk = ~S_AXI_clk;
    end

    // Acknowledge strobes are single-cycle pulses
    in_ack_width: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        reg_in_ack_stb |=> !reg_in_ack_stb)
    else begin
        $display("Write acknowledge stayed high for more than one cycle");
        error_count++;
    end

    out_rdy_width: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        reg_out_rdy_stb |=> !reg_out_rdy_stb)
    else begin
        $display("Read acknowledge stayed high for more than one cycle");
        error_count++;
    end

    // 8-bit Fibonacci LFSR, x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3];
        lfsr_state = {lfsr_state[6:0], fb};
        return fb;
    endfunction

    function automatic sample_t random_sample();
        sample_t s;
        s = '0;
        for (int k = 0; k < 6; k++) begin
            s = {s[14:0], lfsr_bit()};
        end
        return s;
    endfunction

    function automatic score_t abs_diff(input sample_t a, input sample_t b);
        return (a > b) ? score_t'(a - b) : score_t'(b - a);
    endfunction

    // Software subsequence DTW over ref_model and query_buf
    function automatic score_t model_score();
        score_t prev [REF_LEN];
        score_t cur  [REF_LEN];
        score_t pred;
        score_t best;
        for (int j = 0; j < REF_LEN; j++) begin
            prev[j] = abs_diff(query_buf[0], ref_model[j]);
        end
        for (int i = 1; i < QUERY_LEN; i++) begin
            for (int j = 0; j < REF_LEN; j++) begin
                pred = prev[j];
                if (j > 0) begin
                    if (prev[j - 1] < pred) pred = prev[j - 1];
                    if (cur[j - 1] < pred) pred = cur[j - 1];
                end
                cur[j] = pred + abs_diff(query_buf[i], ref_model[j]);
            end
            prev = cur;
        end
        best = prev[0];
        for (int j = 1; j < REF_LEN; j++) begin
            if (prev[j] < best) best = prev[j];
        end
        return best;
    endfunction

    function automatic reg_addr_t word_addr(input logic [3:0] idx);
        return {10'b0, idx, 2'b00};
    endfunction

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s", what);
        error_count++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic reg_write(input logic [3:0] idx, input reg_word_t data,
                             output logic invalid);
        logic got;
        got     = 1'b0;
        invalid = 1'b0;
        @(posedge S_AXI_clk);
        reg_req    <= '{addr: word_addr(idx), wdata: data};
        reg_in_rdy <= 1'b1;
        @(posedge S_AXI_clk);
        reg_in_rdy <= 1'b0;
        for (int t = 0; t < TIMEOUT && !got; t++) begin
            @(negedge S_AXI_clk);
            if (reg_in_ack_stb) begin
                got     = 1'b1;
                invalid = reg_rsp.invalid;
            end
        end
        if (!got) timeout_fail("the write acknowledge");
    endtask

    task automatic reg_read(input logic [3:0] idx, output reg_word_t data,
                            output logic invalid);
        logic got;
        got     = 1'b0;
        data    = '0;
        invalid = 1'b0;
        @(posedge S_AXI_clk);
        reg_req     <= '{addr: word_addr(idx), wdata: '0};
        reg_out_req <= 1'b1;
        @(posedge S_AXI_clk);
        reg_out_req <= 1'b0;
        for (int t = 0; t < TIMEOUT && !got; t++) begin
            @(negedge S_AXI_clk);
            if (reg_out_rdy_stb) begin
                got     = 1'b1;
                data    = reg_rsp.rdata;
                invalid = reg_rsp.invalid;
            end
        end
        if (!got) timeout_fail("the read acknowledge");
    endtask

    task automatic wait_status_bit(input int bit_pos, input string what);
        reg_word_t st;
        logic      inv;
        logic      seen;
        seen = 1'b0;
        for (int n = 0; n < POLL_LIMIT && !seen; n++) begin
            reg_read(REG_STATUS, st, inv);
            if (st[bit_pos]) seen = 1'b1;
        end
        if (!seen) timeout_fail(what);
    endtask

    task automatic push_sample(input sample_t s);
        logic ready;
        ready = 1'b0;
        for (int t = 0; t < TIMEOUT && !ready; t++) begin
            @(negedge S_AXI_clk);
            ready = src_ready;
        end
        if (!ready) begin
            timeout_fail("room in the source FIFO");
        end else begin
            @(posedge S_AXI_clk);
            src_stb    <= 1'b1;
            src_sample <= s;
            @(posedge S_AXI_clk);
            src_stb    <= 1'b0;
        end
    endtask

    task automatic pop_score(output score_t s);
        logic valid;
        valid = 1'b0;
        s     = '0;
        for (int t = 0; t < TIMEOUT && !valid; t++) begin
            @(negedge S_AXI_clk);
            valid = sink_valid;
        end
        if (!valid) begin
            timeout_fail("a score in the sink FIFO");
        end else begin
            s = sink_score;
            @(posedge S_AXI_clk);
            sink_rd_stb <= 1'b1;
            @(posedge S_AXI_clk);
            sink_rd_stb <= 1'b0;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("Test %s: PASS", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL (%0d errors)", name, error_count - errors_before);
        end
    endtask

    task automatic read_id_regs();
        reg_word_t d;
        logic      inv;
        int        e0;
        e0 = error_count;
        reg_read(REG_KEY, d, inv);
        check_value("KEY", d, 32'h0ca7cafe);
        check_value("o_reg_rsp.invalid", inv, 0);
        reg_read(REG_VERSION, d, inv);
        check_value("VERSION", d, 32'h10000000);
        reg_write(REG_REF_LEN, 32'h1f, inv);
        check_value("o_reg_rsp.invalid", inv, 0);
        reg_read(REG_REF_LEN, d, inv);
        check_value("REF_LEN", d, 32'h1f);
        // Mode 1 with run low keeps the core idle
        reg_write(REG_CONTROL, 32'h4, inv);
        reg_read(REG_CONTROL, d, inv);
        check_value("CONTROL", d, 32'h4);
        report_test("id and readback registers", e0);
    endtask

    task automatic probe_invalid_addr();
        reg_word_t d;
        logic      inv;
        int        e0;
        e0 = error_count;
        reg_read(4'd9, d, inv);
        check_value("o_reg_rsp.invalid", inv, 1);
        check_value("o_reg_rsp.rdata", d, 0);
        reg_write(4'd9, 32'hdeadbeef, inv);
        check_value("o_reg_rsp.invalid", inv, 1);
        reg_read(REG_REF_LEN, d, inv);
        check_value("REF_LEN", d, 32'h1f);
        reg_read(REG_CONTROL, d, inv);
        check_value("CONTROL", d, 32'h4);
        report_test("invalid address", e0);
    endtask

    task automatic load_reference();
        reg_word_t d;
        logic      inv;
        int        e0;
        e0 = error_count;
        reg_write(REG_REF_LEN, REF_LEN, inv);
        reg_write(REG_CONTROL, 32'h2, inv);
        for (int j = 0; j < REF_LEN; j++) begin
            ref_model[j] = random_sample();
            push_sample(ref_model[j]);
        end
        wait_status_bit(ST_LOAD_DONE, "load done");
        reg_read(REG_STATUS, d, inv);
        check_value("STATUS.SRC_EMPTY", d[ST_SRC_EMPTY], 1);
        report_test("reference load", e0);
    endtask

    task automatic run_queries();
        reg_word_t d;
        score_t    got;
        logic      inv;
        int        e0;
        e0 = error_count;
        reg_write(REG_CONTROL, 32'h6, inv);
        for (int q = 0; q < 3; q++) begin
            for (int i = 0; i < QUERY_LEN; i++) begin
                query_buf[i] = random_sample();
                push_sample(query_buf[i]);
            end
            pop_score(got);
            check_value("o_sink_score", got, model_score());
        end
        reg_read(REG_NQUERY, d, inv);
        check_value("NQUERY", d, 3);
        report_test("query scores", e0);
    endtask

    task automatic stall_sink();
        score_t    expected_q [$];
        score_t    got;
        reg_word_t d;
        logic      inv;
        int        e0;
        e0 = error_count;
        // Sink holds four, the fifth waits in the engine, the sixth sits in the source FIFO
        for (int q = 0; q < 6; q++) begin
            for (int i = 0; i < QUERY_LEN; i++) begin
                query_buf[i] = random_sample();
                push_sample(query_buf[i]);
            end
            expected_q.push_back(model_score());
        end
        wait_status_bit(ST_SINK_FULL, "a full sink FIFO");
        reg_read(REG_STATUS, d, inv);
        check_value("STATUS.SRC_FULL", d[ST_SRC_FULL], 1);
        check_value("STATUS.BUSY", d[ST_BUSY], 1);
        check_value("o_src_ready", src_ready, 0);
        for (int q = 0; q < 6; q++) begin
            pop_score(got);
            check_value("o_sink_score", got, expected_q.pop_front());
        end
        wait_status_bit(ST_SINK_EMPTY, "an empty sink FIFO");
        reg_read(REG_NQUERY, d, inv);
        check_value("NQUERY", d, 9);
        report_test("sink back-pressure", e0);
    endtask

    task automatic apply_core_reset();
        reg_word_t d;
        logic      inv;
        int        e0;
        e0 = error_count;
        // Park two samples in the source FIFO with run low
        reg_write(REG_CONTROL, 32'h4, inv);
        push_sample(random_sample());
        push_sample(random_sample());
        reg_read(REG_STATUS, d, inv);
        check_value("STATUS.SRC_EMPTY", d[ST_SRC_EMPTY], 0);
        reg_write(REG_CONTROL, 32'h1, inv);
        reg_read(REG_STATUS, d, inv);
        check_value("STATUS.LOAD_DONE", d[ST_LOAD_DONE], 0);
        check_value("STATUS.SRC_EMPTY", d[ST_SRC_EMPTY], 1);
        reg_read(REG_NQUERY, d, inv);
        check_value("NQUERY", d, 0);
        report_test("core reset", e0);
    endtask

    initial begin
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        lfsr_state   = 8'd67;
        w_axi_rst   <= 1'b1;
        reg_req     <= '0;
        reg_in_rdy  <= 1'b0;
        reg_out_req <= 1'b0;
        src_stb     <= 1'b0;
        src_sample  <= '0;
        sink_rd_stb <= 1'b0;
        repeat (8) @(posedge S_AXI_clk);
        w_axi_rst <= 1'b0;

        read_id_regs();
        probe_invalid_addr();
        load_reference();
        run_queries();
        stall_sink();
        apply_core_reset();

        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
